/* rtl/cu_pkg.sv */
// Shared widths, mode encoding and configuration field layout
// of the memory-copy compute unit
package cu_pkg;

	// Datapath widths
	localparam int ADDR_W  = 32;
	localparam int DATA_W  = 64;
	localparam int COUNT_W = 16;

	// Configuration word layout
	localparam int CFG_W         = 8;
	localparam int CFG_SHIFT_LSB = 4;
	localparam int CFG_SHIFT_W   = 3;
	localparam int CFG_SHIFT_DIR = 7;

	// Job mode, low two configuration bits
	typedef enum logic [1:0] {
		MODE_IDLE = 2'd0,
		MODE_READ = 2'd1,
		MODE_COPY = 2'd2
	} cu_mode_t;

	// Unused encoding 3 falls back to idle
	function automatic cu_mode_t decode_mode(input logic [CFG_W-1:0] cfg);
		cu_mode_t mode;
		case (cfg[1:0])
			2'd1: mode = MODE_READ;
			2'd2: mode = MODE_COPY;
			default: mode = MODE_IDLE;
		endcase
		return mode;
	endfunction

endpackage

/* rtl/cu_data_buffer.sv */
// First-word-fall-through FIFO carrying returned lines and their indices
module cu_data_buffer #(
	parameter int BUF_DEPTH = 8
) (
	input  logic                       clock,
	input  logic                       rstn,
	input  logic                       push,
	input  logic [cu_pkg::COUNT_W-1:0] push_index,
	input  logic [cu_pkg::DATA_W-1:0]  push_data,
	input  logic                       pop,
	output logic [cu_pkg::COUNT_W-1:0] pop_index,
	output logic [cu_pkg::DATA_W-1:0]  pop_data,
	output logic                       buf_empty,
	output logic [cu_pkg::COUNT_W-1:0] buf_free
);
	import cu_pkg::*;

	localparam int PTR_W = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
	localparam int OCC_W = $clog2(BUF_DEPTH + 1);

	logic [COUNT_W-1:0] index_mem [BUF_DEPTH];
	logic [DATA_W-1:0]  data_mem  [BUF_DEPTH];
	logic [PTR_W-1:0]   wr_ptr;
	logic [PTR_W-1:0]   rd_ptr;
	logic [OCC_W-1:0]   occupancy;

	// Circular wrap, depth need not be a power of two
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(BUF_DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	always_ff @(posedge clock) begin
		if (push) begin
			index_mem[wr_ptr] <= push_index;
			data_mem[wr_ptr]  <= push_data;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			occupancy <= '0;
		end else begin
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			case ({push, pop})
				2'b10: occupancy <= occupancy + 1'b1;
				2'b01: occupancy <= occupancy - 1'b1;
				default: ;
			endcase
		end
	end

	// Head entry is visible without a pop
	assign pop_index = index_mem[rd_ptr];
	assign pop_data  = data_mem[rd_ptr];
	assign buf_empty = (occupancy == '0);
	assign buf_free  = COUNT_W'(BUF_DEPTH) - COUNT_W'(occupancy);

endmodule

/* rtl/cu_read_engine.sv */
// Read engine: issues line reads, bounds in-flight reads,
// forwards returned lines to the data buffer and counts them
module cu_read_engine (
	input  logic                       clock,
	input  logic                       rstn,
	input  logic                       run_read,
	input  logic [cu_pkg::ADDR_W-1:0]  job_src,
	input  logic [cu_pkg::COUNT_W-1:0] job_size,
	input  logic [cu_pkg::COUNT_W-1:0] inflight_limit,
	input  logic                       cmd_full,
	input  logic                       rsp_valid,
	input  logic [cu_pkg::COUNT_W-1:0] rsp_tag,
	input  logic [cu_pkg::DATA_W-1:0]  rsp_data,
	input  logic                       keep_data,
	input  logic [cu_pkg::COUNT_W-1:0] buf_free,
	output logic                       cmd_valid,
	output logic [cu_pkg::ADDR_W-1:0]  cmd_addr,
	output logic [cu_pkg::COUNT_W-1:0] cmd_tag,
	output logic                       push,
	output logic [cu_pkg::COUNT_W-1:0] push_index,
	output logic [cu_pkg::DATA_W-1:0]  push_data,
	output logic [cu_pkg::COUNT_W-1:0] read_done_count
);
	import cu_pkg::*;

	logic [COUNT_W-1:0] issue_index;
	logic [COUNT_W-1:0] inflight;
	logic               lines_left;
	logic               under_limit;
	logic               buf_room;
	logic               rsp_take;

	////////////////////////////////////////
	// Issue side
	////////////////////////////////////////

	assign lines_left  = (issue_index < job_size);
	assign under_limit = (inflight < inflight_limit);
	// Every in-flight read holds a buffer slot, so pushes always fit
	assign buf_room    = !keep_data || (buf_free > inflight);

	assign cmd_valid = run_read && lines_left && under_limit && buf_room && !cmd_full;
	assign cmd_addr  = job_src + ADDR_W'(issue_index);
	assign cmd_tag   = issue_index;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			issue_index <= '0;
		end else if (!run_read) begin
			issue_index <= '0;
		end else if (cmd_valid) begin
			issue_index <= issue_index + 1'b1;
		end
	end

	////////////////////////////////////////
	// Response side
	////////////////////////////////////////

	assign rsp_take   = run_read && rsp_valid;
	// Tag carries the line index, order of return does not matter
	assign push       = rsp_take && keep_data;
	assign push_index = rsp_tag;
	assign push_data  = rsp_data;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			inflight        <= '0;
			read_done_count <= '0;
		end else if (!run_read) begin
			inflight        <= '0;
			read_done_count <= '0;
		end else begin
			case ({cmd_valid, rsp_take})
				2'b10: inflight <= inflight + 1'b1;
				2'b01: inflight <= inflight - 1'b1;
				default: ;
			endcase
			if (rsp_take)
				read_done_count <= read_done_count + 1'b1;
		end
	end

endmodule

/* rtl/cu_write_engine.sv */
// Write engine: drains buffered lines into write commands
// and counts write responses
module cu_write_engine (
	input  logic                       clock,
	input  logic                       rstn,
	input  logic                       run_write,
	input  logic [cu_pkg::ADDR_W-1:0]  job_dst,
	input  logic                       buf_empty,
	input  logic [cu_pkg::COUNT_W-1:0] pop_index,
	input  logic [cu_pkg::DATA_W-1:0]  pop_data,
	input  logic                       cmd_full,
	input  logic                       rsp_valid,
	output logic                       pop,
	output logic                       cmd_valid,
	output logic [cu_pkg::ADDR_W-1:0]  cmd_addr,
	output logic [cu_pkg::DATA_W-1:0]  cmd_data,
	output logic [cu_pkg::COUNT_W-1:0] write_done_count
);
	import cu_pkg::*;

	logic               pend_valid;
	logic [COUNT_W-1:0] pend_index;
	logic [DATA_W-1:0]  pend_data;

	////////////////////////////////////////
	// Pop and issue
	////////////////////////////////////////

	// Staged line waits here while the write side is full
	assign cmd_valid = run_write && pend_valid && !cmd_full;
	assign pop       = run_write && !buf_empty && !cmd_full && (!pend_valid || cmd_valid);

	// Same line index at the destination
	assign cmd_addr = job_dst + ADDR_W'(pend_index);
	assign cmd_data = pend_data;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			pend_valid <= 1'b0;
		end else if (!run_write) begin
			pend_valid <= 1'b0;
		end else if (pop) begin
			pend_valid <= 1'b1;
		end else if (cmd_valid) begin
			pend_valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (pop) begin
			pend_index <= pop_index;
			pend_data  <= pop_data;
		end
	end

	////////////////////////////////////////
	// Response count
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			write_done_count <= '0;
		end else if (!run_write) begin
			write_done_count <= '0;
		end else if (rsp_valid) begin
			write_done_count <= write_done_count + 1'b1;
		end
	end

endmodule

/* rtl/cu_control.sv */
// Memory-copy compute unit top: I/O registers, configuration decode,
// in-flight limit, return counters and done
module cu_control #(
	parameter int MAX_INFLIGHT = 16,
	parameter int BUF_DEPTH    = 8
) (
	input  logic                       clock,
	input  logic                       rstn,
	input  logic                       enable,
	input  logic [cu_pkg::CFG_W-1:0]   config_word,
	input  logic                       job_valid,
	input  logic [cu_pkg::ADDR_W-1:0]  job_src,
	input  logic [cu_pkg::ADDR_W-1:0]  job_dst,
	input  logic [cu_pkg::COUNT_W-1:0] job_size,
	output logic                       read_cmd_valid,
	output logic [cu_pkg::ADDR_W-1:0]  read_cmd_addr,
	output logic [cu_pkg::COUNT_W-1:0] read_cmd_tag,
	input  logic                       read_cmd_full,
	input  logic                       read_rsp_valid,
	input  logic [cu_pkg::COUNT_W-1:0] read_rsp_tag,
	input  logic [cu_pkg::DATA_W-1:0]  read_rsp_data,
	output logic                       write_cmd_valid,
	output logic [cu_pkg::ADDR_W-1:0]  write_cmd_addr,
	output logic [cu_pkg::DATA_W-1:0]  write_cmd_data,
	input  logic                       write_cmd_full,
	input  logic                       write_rsp_valid,
	output logic                       cu_done,
	output logic [cu_pkg::COUNT_W-1:0] cu_return_primary,
	output logic [cu_pkg::COUNT_W-1:0] cu_return_secondary,
	output logic [cu_pkg::CFG_W-1:0]   cu_status
);
	import cu_pkg::*;

	logic rstn_q;
	logic enabled;

	// Registered inputs
	logic [CFG_W-1:0]   cfg_q;
	logic               job_valid_q;
	logic [ADDR_W-1:0]  job_src_q;
	logic [ADDR_W-1:0]  job_dst_q;
	logic [COUNT_W-1:0] job_size_q;
	logic               rd_full_q;
	logic               wr_full_q;
	logic               rd_rsp_valid_q;
	logic [COUNT_W-1:0] rd_rsp_tag_q;
	logic [DATA_W-1:0]  rd_rsp_data_q;
	logic               wr_rsp_valid_q;

	// Control and status
	cu_mode_t                 mode;
	logic [CFG_SHIFT_W-1:0]   shift;
	logic [COUNT_W-1:0]       inflight_limit;
	logic                     run_read;
	logic                     run_write;
	logic                     rd_stall;
	logic                     wr_stall;
	logic                     done_next;
	logic [COUNT_W-1:0]       return_primary;
	logic [COUNT_W-1:0]       return_secondary;
	logic [COUNT_W-1:0]       read_done_count;
	logic [COUNT_W-1:0]       write_done_count;

	// Engine and buffer nets
	logic               rd_cmd_valid;
	logic [ADDR_W-1:0]  rd_cmd_addr;
	logic [COUNT_W-1:0] rd_cmd_tag;
	logic               wr_cmd_valid;
	logic [ADDR_W-1:0]  wr_cmd_addr;
	logic [DATA_W-1:0]  wr_cmd_data;
	logic               push;
	logic [COUNT_W-1:0] push_index;
	logic [DATA_W-1:0]  push_data;
	logic               pop;
	logic [COUNT_W-1:0] pop_index;
	logic [DATA_W-1:0]  pop_data;
	logic               buf_empty;
	logic [COUNT_W-1:0] buf_free;

	////////////////////////////////////////
	// Reset sync and enable
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			rstn_q <= 1'b0;
		else
			rstn_q <= 1'b1;
	end

	always_ff @(posedge clock or negedge rstn_q) begin
		if (!rstn_q)
			enabled <= 1'b0;
		else
			enabled <= enable;
	end

	////////////////////////////////////////
	// Input registers
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn_q) begin
		if (!rstn_q) begin
			cfg_q          <= '0;
			job_valid_q    <= 1'b0;
			rd_full_q      <= 1'b0;
			wr_full_q      <= 1'b0;
			rd_rsp_valid_q <= 1'b0;
			wr_rsp_valid_q <= 1'b0;
		end else begin
			// Strobes drop while disabled so a held value is never counted twice
			rd_rsp_valid_q <= enabled && read_rsp_valid;
			wr_rsp_valid_q <= enabled && write_rsp_valid;
			if (enabled) begin
				job_valid_q <= job_valid;
				rd_full_q   <= read_cmd_full;
				wr_full_q   <= write_cmd_full;
				// Zero word keeps the last configuration
				if (|config_word)
					cfg_q <= config_word;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (enabled) begin
			job_src_q     <= job_src;
			job_dst_q     <= job_dst;
			job_size_q    <= job_size;
			rd_rsp_tag_q  <= read_rsp_tag;
			rd_rsp_data_q <= read_rsp_data;
		end
	end

	////////////////////////////////////////
	// Mode, run levels, in-flight limit
	////////////////////////////////////////

	assign mode  = decode_mode(cfg_q);
	assign shift = cfg_q[CFG_SHIFT_LSB +: CFG_SHIFT_W];

	// Run follows the job only; pausing goes through the stall levels
	always_ff @(posedge clock or negedge rstn_q) begin
		if (!rstn_q) begin
			run_read  <= 1'b0;
			run_write <= 1'b0;
		end else begin
			run_read  <= job_valid_q && (mode == MODE_READ || mode == MODE_COPY);
			run_write <= job_valid_q && (mode == MODE_COPY);
		end
	end

	always_ff @(posedge clock or negedge rstn_q) begin
		if (!rstn_q) begin
			inflight_limit <= '0;
		end else if (|cfg_q) begin
			if (cfg_q[CFG_SHIFT_DIR])
				inflight_limit <= (COUNT_W'(MAX_INFLIGHT) >> shift) - 1'b1;
			else
				inflight_limit <= (COUNT_W'(MAX_INFLIGHT) << shift) - 1'b1;
		end
	end

	assign rd_stall = rd_full_q || !enabled;
	assign wr_stall = wr_full_q || !enabled;

	////////////////////////////////////////
	// Engines and line buffer
	////////////////////////////////////////

	cu_read_engine read_engine_i (
		.clock          (clock          ),
		.rstn           (rstn_q         ),
		.run_read       (run_read       ),
		.job_src        (job_src_q      ),
		.job_size       (job_size_q     ),
		.inflight_limit (inflight_limit ),
		.cmd_full       (rd_stall       ),
		.rsp_valid      (rd_rsp_valid_q ),
		.rsp_tag        (rd_rsp_tag_q   ),
		.rsp_data       (rd_rsp_data_q  ),
		.keep_data      (run_write      ),
		.buf_free       (buf_free       ),
		.cmd_valid      (rd_cmd_valid   ),
		.cmd_addr       (rd_cmd_addr    ),
		.cmd_tag        (rd_cmd_tag     ),
		.push           (push           ),
		.push_index     (push_index     ),
		.push_data      (push_data      ),
		.read_done_count(read_done_count)
	);

	cu_data_buffer #(
		.BUF_DEPTH(BUF_DEPTH)
	) data_buffer_i (
		.clock     (clock     ),
		.rstn      (rstn_q    ),
		.push      (push      ),
		.push_index(push_index),
		.push_data (push_data ),
		.pop       (pop       ),
		.pop_index (pop_index ),
		.pop_data  (pop_data  ),
		.buf_empty (buf_empty ),
		.buf_free  (buf_free  )
	);

	cu_write_engine write_engine_i (
		.clock           (clock           ),
		.rstn            (rstn_q          ),
		.run_write       (run_write       ),
		.job_dst         (job_dst_q       ),
		.buf_empty       (buf_empty       ),
		.pop_index       (pop_index       ),
		.pop_data        (pop_data        ),
		.cmd_full        (wr_stall        ),
		.rsp_valid       (wr_rsp_valid_q  ),
		.pop             (pop             ),
		.cmd_valid       (wr_cmd_valid    ),
		.cmd_addr        (wr_cmd_addr     ),
		.cmd_data        (wr_cmd_data     ),
		.write_done_count(write_done_count)
	);

	////////////////////////////////////////
	// Done and return counters
	////////////////////////////////////////

	always_comb begin
		done_next        = 1'b0;
		return_primary   = write_done_count;
		return_secondary = read_done_count;
		case (mode)
			MODE_READ: begin
				return_primary   = read_done_count;
				return_secondary = write_done_count;
				done_next        = job_valid_q && (read_done_count == job_size_q);
			end
			MODE_COPY: begin
				done_next = job_valid_q && (write_done_count == job_size_q)
					&& (read_done_count == job_size_q);
			end
			default: ;
		endcase
	end

	////////////////////////////////////////
	// Output registers
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn_q) begin
		if (!rstn_q) begin
			read_cmd_valid      <= 1'b0;
			write_cmd_valid     <= 1'b0;
			cu_done             <= 1'b0;
			cu_return_primary   <= '0;
			cu_return_secondary <= '0;
			cu_status           <= '0;
		end else begin
			read_cmd_valid      <= rd_cmd_valid;
			write_cmd_valid     <= wr_cmd_valid;
			cu_done             <= done_next;
			cu_return_primary   <= return_primary;
			cu_return_secondary <= return_secondary;
			cu_status           <= cfg_q;
		end
	end

	always_ff @(posedge clock) begin
		read_cmd_addr  <= rd_cmd_addr;
		read_cmd_tag   <= rd_cmd_tag;
		write_cmd_addr <= wr_cmd_addr;
		write_cmd_data <= wr_cmd_data;
	end

endmodule

/* bench/cu_control_chk.sv */
// Bound port checker of the compute unit with command, write data, in-flight,
// back-pressure, enable, reset, status and completion assertions
module cu_control_chk #(
	parameter logic [cu_pkg::DATA_W-1:0] MEM_PATTERN  = '0,
	parameter int                        MAX_INFLIGHT = 16
) (
	input logic                       clock,
	input logic                       rstn,
	input logic                       enable,
	input logic [cu_pkg::CFG_W-1:0]   config_word,
	input logic                       job_valid,
	input logic [cu_pkg::ADDR_W-1:0]  job_src,
	input logic [cu_pkg::ADDR_W-1:0]  job_dst,
	input logic [cu_pkg::COUNT_W-1:0] job_size,
	input logic                       read_cmd_valid,
	input logic [cu_pkg::ADDR_W-1:0]  read_cmd_addr,
	input logic [cu_pkg::COUNT_W-1:0] read_cmd_tag,
	input logic                       read_cmd_full,
	input logic                       read_rsp_valid,
	input logic                       write_cmd_valid,
	input logic [cu_pkg::ADDR_W-1:0]  write_cmd_addr,
	input logic [cu_pkg::DATA_W-1:0]  write_cmd_data,
	input logic                       write_cmd_full,
	input logic                       cu_done,
	input logic [cu_pkg::COUNT_W-1:0] cu_return_primary,
	input logic [cu_pkg::COUNT_W-1:0] cu_return_secondary,
	input logic [cu_pkg::CFG_W-1:0]   cu_status
);
	timeunit 1ns;
	timeprecision 1ps;
	import cu_pkg::*;

	int unsigned fail_count = 0;

	logic [63:0]            issued;
	int                     issued_count;
	int                     outstanding;
	int                     limit;
	logic [CFG_SHIFT_W-1:0] shift;
	logic                   enable_q;
	logic [CFG_W-1:0]       cfg_model;
	logic [CFG_W-1:0]       cfg_expect;

	// Last nonzero configuration taken while enabled, one stage more at the status port
	always @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enable_q   <= 1'b0;
			cfg_model  <= '0;
			cfg_expect <= '0;
		end else begin
			enable_q   <= enable;
			cfg_expect <= cfg_model;
			if (enable_q && config_word != '0)
				cfg_model <= config_word;
		end
	end

	// Base budget scaled by the shift field, then one less
	assign shift = cfg_expect[CFG_SHIFT_LSB +: CFG_SHIFT_W];
	assign limit = cfg_expect[CFG_SHIFT_DIR] ? (MAX_INFLIGHT >> shift) - 1
		: (MAX_INFLIGHT << shift) - 1;

	// Tags seen in the current job and reads outstanding at the ports
	always @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			issued       <= '0;
			issued_count <= 0;
			outstanding  <= 0;
		end else begin
			if (!job_valid) begin
				issued       <= '0;
				issued_count <= 0;
			end else if (read_cmd_valid) begin
				issued[read_cmd_tag[5:0]] <= 1'b1;
				issued_count              <= issued_count + 1;
			end
			case ({read_cmd_valid, read_rsp_valid})
				2'b10: outstanding <= outstanding + 1;
				2'b01: outstanding <= outstanding - 1;
				default: ;
			endcase
		end
	end

	////////////////////////////////////////
	// Command streams
	////////////////////////////////////////

	read_addr_a: assert property (@(posedge clock) disable iff (!rstn)
		read_cmd_valid |-> read_cmd_addr == job_src + ADDR_W'(read_cmd_tag))
	else begin
		fail_count++;
		$error("mismatch at %0t: read address %h for tag %0d", $time, read_cmd_addr,
			read_cmd_tag);
	end

	read_tag_once_a: assert property (@(posedge clock) disable iff (!rstn)
		read_cmd_valid |-> read_cmd_tag < job_size && !issued[read_cmd_tag[5:0]])
	else begin
		fail_count++;
		$error("read tag %0d was issued twice or lies outside the job at %0t",
			read_cmd_tag, $time);
	end

	write_data_a: assert property (@(posedge clock) disable iff (!rstn)
		write_cmd_valid |-> write_cmd_data
			== ({32'h0, write_cmd_addr - job_dst + job_src} ^ MEM_PATTERN))
	else begin
		fail_count++;
		$error("mismatch at %0t: write data %h at address %h", $time, write_cmd_data,
			write_cmd_addr);
	end

	inflight_a: assert property (@(posedge clock) disable iff (!rstn)
		outstanding <= limit)
	else begin
		fail_count++;
		$error("%0d reads in flight exceed the limit of %0d at %0t", outstanding, limit,
			$time);
	end

	////////////////////////////////////////
	// Back-pressure, enable and configuration
	////////////////////////////////////////

	read_full_a: assert property (@(posedge clock) disable iff (!rstn)
		read_cmd_full && $past(read_cmd_full) && $past(read_cmd_full, 2) |-> !read_cmd_valid)
	else begin
		fail_count++;
		$error("read command issued while the read side stayed full at %0t", $time);
	end

	write_full_a: assert property (@(posedge clock) disable iff (!rstn)
		write_cmd_full && $past(write_cmd_full) && $past(write_cmd_full, 2)
			|-> !write_cmd_valid)
	else begin
		fail_count++;
		$error("write command issued while the write side stayed full at %0t", $time);
	end

	enable_low_a: assert property (@(posedge clock) disable iff (!rstn)
		!enable && !$past(enable) && !$past(enable, 2) |-> !read_cmd_valid && !write_cmd_valid)
	else begin
		fail_count++;
		$error("command issued while the unit was disabled at %0t", $time);
	end

	status_a: assert property (@(posedge clock) disable iff (!rstn)
		cu_status == cfg_expect)
	else begin
		fail_count++;
		$error("mismatch at %0t: status %h, expected %h", $time, cu_status, cfg_expect);
	end

	reset_a: assert property (@(posedge clock)
		!rstn |=> !read_cmd_valid && !write_cmd_valid && !cu_done
			&& cu_return_primary == '0 && cu_return_secondary == '0)
	else begin
		fail_count++;
		$error("strobes, done or counters not cleared by reset at %0t", $time);
	end

	////////////////////////////////////////
	// Completion per mode
	////////////////////////////////////////

	read_done_a: assert property (@(posedge clock) disable iff (!rstn)
		$rose(cu_done) && cfg_expect[1:0] == 2'd1 |-> cu_return_primary == job_size
			&& cu_return_secondary == '0 && issued_count == int'(job_size))
	else begin
		fail_count++;
		$error("mismatch at %0t: read job done with counters %0d and %0d", $time,
			cu_return_primary, cu_return_secondary);
	end

	copy_done_a: assert property (@(posedge clock) disable iff (!rstn)
		$rose(cu_done) && cfg_expect[1:0] == 2'd2 |-> cu_return_primary == job_size
			&& cu_return_secondary == job_size)
	else begin
		fail_count++;
		$error("mismatch at %0t: copy job done with counters %0d and %0d", $time,
			cu_return_primary, cu_return_secondary);
	end

endmodule

/* bench/cu_control_tb.sv */
// Testbench of the compute unit with clock, reset, shuffling memory model,
// job sequence, watchdog and result reporting
module cu_control_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [63:0] MEM_PATTERN = 64'hc3a5_5a3c_0ff0_9669;
	localparam int          RD_CAP      = 8;
	localparam int          TOTAL_LINES = 12 + 20 + 16 * 5;

	logic        clock           = 1'b0;
	logic        rstn            = 1'b0;
	logic        enable          = 1'b1;
	logic [7:0]  config_word     = '0;
	logic        job_valid       = 1'b0;
	logic [31:0] job_src         = '0;
	logic [31:0] job_dst         = '0;
	logic [15:0] job_size        = '0;
	logic        read_cmd_full   = 1'b0;
	logic        read_rsp_valid  = 1'b0;
	logic [15:0] read_rsp_tag    = '0;
	logic [63:0] read_rsp_data   = '0;
	logic        write_cmd_full  = 1'b0;
	logic        write_rsp_valid = 1'b0;

	logic        read_cmd_valid;
	logic [31:0] read_cmd_addr;
	logic [15:0] read_cmd_tag;
	logic        write_cmd_valid;
	logic [31:0] write_cmd_addr;
	logic [63:0] write_cmd_data;
	logic        cu_done;
	logic [15:0] cu_return_primary;
	logic [15:0] cu_return_secondary;
	logic [7:0]  cu_status;

	// Memory model state
	logic [31:0] rng_state   = 32'h8bc2_f1d9;
	logic [3:0]  full_weight = 4'd3;
	logic [47:0] read_q[$];
	int          write_pending = 0;

	int unsigned fails_before = 0;
	int          tests_passed = 0;
	int          tests_failed = 0;

	cu_control #(
		.MAX_INFLIGHT(16),
		.BUF_DEPTH   (8 )
	) dut_i (.*);

	// Same pattern as MEM_PATTERN above
	bind cu_control cu_control_chk #(
		.MEM_PATTERN (64'hc3a5_5a3c_0ff0_9669),
		.MAX_INFLIGHT(MAX_INFLIGHT)
	) chk_i (.*);

	initial begin
		forever #10 clock = ~clock;
	end

	function automatic logic [31:0] next_random(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	////////////////////////////////////////
	// Memory model
	////////////////////////////////////////

	// Responds only while enabled and picks a random pending read each time
	always @(posedge clock) begin
		int unsigned pick;
		logic [47:0] entry;
		rng_state = next_random(rng_state);
		read_rsp_valid  <= 1'b0;
		write_rsp_valid <= 1'b0;
		if (rstn && enable && read_q.size() > 0 && rng_state[1:0] != 2'b00) begin
			pick  = 32'(rng_state[15:8]) % read_q.size();
			entry = read_q[pick];
			read_q.delete(pick);
			read_rsp_valid <= 1'b1;
			read_rsp_tag   <= entry[47:32];
			read_rsp_data  <= {32'h0, entry[31:0]} ^ MEM_PATTERN;
		end
		if (read_cmd_valid)
			read_q.push_back({read_cmd_tag, read_cmd_addr});
		if (rstn && enable && write_pending > 0 && rng_state[5:4] != 2'b00) begin
			write_rsp_valid <= 1'b1;
			write_pending   = write_pending - 1;
		end
		if (write_cmd_valid)
			write_pending = write_pending + 1;
		// Full goes up with two entries of slack left
		read_cmd_full  <= enable && (rng_state[19:16] < full_weight
			|| read_q.size() >= RD_CAP - 2);
		write_cmd_full <= enable && (rng_state[23:20] < full_weight);
	end

	////////////////////////////////////////
	// Job sequence
	////////////////////////////////////////

	task automatic wait_done();
		@(posedge clock);
		while (!cu_done)
			@(posedge clock);
	endtask

	task automatic run_job(input logic [7:0] cfg, input logic [31:0] src,
			input logic [31:0] dst, input logic [15:0] size, input bit pause);
		@(posedge clock);
		config_word <= cfg;
		job_src     <= src;
		job_dst     <= dst;
		job_size    <= size;
		@(posedge clock);
		config_word <= '0;
		repeat (3) @(posedge clock);
		job_valid <= 1'b1;
		if (pause) begin
			repeat (12) @(posedge clock);
			enable <= 1'b0;
			repeat (8) @(posedge clock);
			enable <= 1'b1;
		end
		wait_done();
		job_valid <= 1'b0;
		repeat (4) @(posedge clock);
	endtask

	task automatic start_test();
		fails_before = dut_i.chk_i.fail_count;
	endtask

	task automatic finish_test(input int id, input string name);
		int unsigned new_fails;
		new_fails = dut_i.chk_i.fail_count - fails_before;
		if (new_fails == 0) begin
			tests_passed++;
			$display("test %0d %s: ok", id, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: %0d assertion failures", id, name, new_fails);
		end
	endtask

	initial begin
		repeat (8) @(posedge clock);
		rstn <= 1'b1;
		repeat (4) @(posedge clock);

		start_test();
		run_job(8'h01, 32'h0000_1000, 32'h0000_8000, 16'd12, 1'b0);
		finish_test(1, "read mode, 12 lines");

		start_test();
		run_job(8'h02, 32'h0001_2340, 32'h0004_0000, 16'd20, 1'b0);
		finish_test(2, "copy mode, 20 lines");

		// Limits of 31, 3 and 1
		start_test();
		run_job(8'h12, 32'h0002_0000, 32'h0005_0000, 16'd16, 1'b0);
		run_job(8'ha1, 32'h0002_8000, 32'h0005_8000, 16'd16, 1'b0);
		run_job(8'hb2, 32'h0003_0000, 32'h0006_0000, 16'd16, 1'b0);
		finish_test(3, "in-flight limit");

		start_test();
		full_weight <= 4'd9;
		run_job(8'h02, 32'h0003_8000, 32'h0006_8000, 16'd16, 1'b0);
		full_weight <= 4'd3;
		finish_test(4, "back-pressure");

		start_test();
		run_job(8'h22, 32'h0004_4000, 32'h0007_0000, 16'd16, 1'b1);
		finish_test(5, "enable and reset");

		$display("tests passed %0d, failed %0d, assertion failures %0d", tests_passed,
			tests_failed, dut_i.chk_i.fail_count);
		if (tests_failed == 0 && dut_i.chk_i.fail_count == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	// Budget of 40 cycles per line over all jobs
	initial begin
		repeat (TOTAL_LINES * 40 + 400) @(posedge clock);
		$display("timeout: jobs did not complete within %0d cycles",
			TOTAL_LINES * 40 + 400);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

/* sources.f */
rtl/cu_pkg.sv
rtl/cu_data_buffer.sv
rtl/cu_read_engine.sv
rtl/cu_write_engine.sv
rtl/cu_control.sv
bench/cu_control_chk.sv
bench/cu_control_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, and decide the result from the log
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
	--top-module cu_control_tb -f sources.f &&
{ ./obj_dir/Vcu_control_tb +verilator+error+limit+1000 > sim.log 2>&1 || true; } &&
cat sim.log &&
grep -q "Simulation finished: PASS" sim.log &&
echo "run passed" ||
{ echo "run failed, see sim.log"; exit 1; }
